// ==== source/dma_pkg.sv ====
// Shared widths, register map, request and memory structs, engine state enum

package dma_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  // Byte address and data word
  localparam int ADDR_WIDTH  = 32;
  localparam int DATA_WIDTH  = 32;
  // Transfer length in words
  localparam int COUNT_WIDTH = 16;
  // Bytes per word, the step between word addresses
  localparam int WORD_BYTES  = 4;

  //////////////////////////////////////////////////
  // Request table geometry and register map
  //////////////////////////////////////////////////

  localparam int TABLE_ENTRIES   = 4;
  localparam int ENTRY_PTR_WIDTH = 2;
  // Byte offset inside one entry window uses haddr[4:0]
  localparam int OFFSET_WIDTH    = 5;
  // Entry index sits right above the offset, haddr[6:5]
  localparam int ENTRY_LSB       = OFFSET_WIDTH;
  // Writable fields per entry
  localparam int REQ_FIELDS      = 4;

  // Field index is offset / 4
  // laddr 0x00, raddr 0x04, size 0x08, dir 0x0C
  localparam int FIELD_LADDR = 0;
  localparam int FIELD_RADDR = 1;
  localparam int FIELD_SIZE  = 2;
  localparam int FIELD_DIR   = 3;

  // Status register, write starts the entry, read returns done in bit 0
  localparam logic [OFFSET_WIDTH-1:0] STATUS_OFFSET = 5'h14;

  //////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////

  typedef logic [ADDR_WIDTH-1:0]      addr_t;
  typedef logic [DATA_WIDTH-1:0]      word_t;
  typedef logic [ENTRY_PTR_WIDTH-1:0] entry_ptr_t;
  typedef logic [REQ_FIELDS-1:0]      field_sel_t;
  typedef logic [TABLE_ENTRIES-1:0]   entry_mask_t;
  typedef logic [COUNT_WIDTH-1:0]     word_count_t;

  // One transfer request
  // dir 0 copies laddr to raddr, dir 1 copies raddr to laddr
  typedef struct packed {
    addr_t       laddr;
    addr_t       raddr;
    word_count_t size;
    logic        dir;
  } dma_req_t;

  // Field write into the table, select is one-hot over the fields
  typedef struct packed {
    dma_req_t   req;
    entry_ptr_t pos;
    field_sel_t select;
    logic       en;
  } table_wr_t;

  // Memory master request
  typedef struct packed {
    logic  valid;
    logic  we;
    addr_t addr;
    word_t wdata;
  } mem_req_t;

  // Transfer engine FSM
  typedef enum logic [1:0] {
    st_idle,
    st_read,
    st_write,
    st_finish
  } engine_state_t;

endpackage

// ==== source/dma_ahb3_interface.sv ====
// AHB3-Lite slave decoding bus accesses into table writes, start commands and status reads

`timescale 1ns/1ps

module dma_ahb3_interface (
  input  logic                clk,
  input  logic                rst_n,

  // AHB3-Lite slave side
  input  logic                hsel,
  input  dma_pkg::addr_t      haddr,
  input  dma_pkg::word_t      hwdata,
  input  logic                hwrite,
  input  logic                hmastlock,
  output dma_pkg::word_t      hrdata,
  output logic                hready,

  // Field writes into the request table
  output dma_pkg::table_wr_t  table_wr,

  // Start command for one entry
  output dma_pkg::entry_ptr_t valid_pos,
  output logic                valid_en,

  // Done flags from the table
  input  dma_pkg::entry_mask_t done
);

  import dma_pkg::*;

  //////////////////////////////////////////////////
  // Address decode
  //////////////////////////////////////////////////

  // Purely combinational slave, clk and rst_n kept for a uniform port list
  entry_ptr_t                 entry_pos;
  logic [OFFSET_WIDTH-1:0]    offset;
  logic [OFFSET_WIDTH-3:0]    field_idx;
  field_sel_t                 field_sel;
  logic                       access;
  logic                       status_hit;

  // Entry window and byte offset inside it
  assign entry_pos  = haddr[ENTRY_LSB +: ENTRY_PTR_WIDTH];
  assign offset     = haddr[OFFSET_WIDTH-1:0];
  assign field_idx  = offset[OFFSET_WIDTH-1:2];

  // Locked, selected cycle is a complete transfer
  assign access     = hsel & hmastlock;
  assign status_hit = (offset == STATUS_OFFSET);

  // One-hot field select, status offset lands outside the field range
  always_comb begin
    for (int i = 0; i < REQ_FIELDS; i++) begin
      field_sel[i] = (field_idx == i) && (offset[1:0] == 2'b00);
    end
  end

  //////////////////////////////////////////////////
  // Table write and start command
  //////////////////////////////////////////////////

  // Same bus word lands in every field, select decides which one is kept
  always_comb begin
    table_wr.req.laddr = hwdata;
    table_wr.req.raddr = hwdata;
    table_wr.req.size  = hwdata[COUNT_WIDTH-1:0];
    table_wr.req.dir   = hwdata[0];
    table_wr.pos       = entry_pos;
    table_wr.select    = field_sel;
    table_wr.en        = access & hwrite & (|field_sel);
  end

  // Write to status kicks off the entry
  assign valid_pos = entry_pos;
  assign valid_en  = access & hwrite & status_hit;

  //////////////////////////////////////////////////
  // Bus response
  //////////////////////////////////////////////////

  // Zero wait states
  assign hready = access;

  // Done bit of the addressed entry, everything else reads zero
  always_comb begin
    hrdata = '0;
    if (status_hit) begin
      hrdata[0] = done[entry_pos];
    end
  end

endmodule

// ==== source/dma_request_table.sv ====
// Request entry storage with valid and done flags and the pending vector

`timescale 1ns/1ps

module dma_request_table (
  input  logic                 clk,
  input  logic                 rst_n,

  // Field writes from the bus side
  input  dma_pkg::table_wr_t   table_wr,

  // Start command from the bus side
  input  dma_pkg::entry_ptr_t  valid_pos,
  input  logic                 valid_en,

  // Entry lookup from the engine
  input  dma_pkg::entry_ptr_t  sel_pos,
  output dma_pkg::dma_req_t    sel_req,

  // Completion from the engine
  input  dma_pkg::entry_ptr_t  finish_pos,
  input  logic                 finish_en,

  // Status
  output dma_pkg::entry_mask_t done,
  output dma_pkg::entry_mask_t pending
);

  import dma_pkg::*;

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////

  // Request fields, written only by the bus
  dma_req_t    entries [TABLE_ENTRIES];

  // Flag registers
  entry_mask_t valid_q;
  entry_mask_t done_q;

  // Decoded start and finish, one bit per entry
  entry_mask_t start_mask;
  entry_mask_t finish_mask;

  //////////////////////////////////////////////////
  // Field writes
  //////////////////////////////////////////////////

  // Each field written on its own, the others in the entry keep their value
  always_ff @(posedge clk) begin
    if (table_wr.en) begin
      if (table_wr.select[FIELD_LADDR]) begin
        entries[table_wr.pos].laddr <= table_wr.req.laddr;
      end
      if (table_wr.select[FIELD_RADDR]) begin
        entries[table_wr.pos].raddr <= table_wr.req.raddr;
      end
      if (table_wr.select[FIELD_SIZE]) begin
        entries[table_wr.pos].size <= table_wr.req.size;
      end
      if (table_wr.select[FIELD_DIR]) begin
        entries[table_wr.pos].dir <= table_wr.req.dir;
      end
    end
  end

  //////////////////////////////////////////////////
  // Valid and done flags
  //////////////////////////////////////////////////

  assign start_mask  = valid_en  ? (entry_mask_t'(1) << valid_pos)  : '0;
  assign finish_mask = finish_en ? (entry_mask_t'(1) << finish_pos) : '0;

  // Start sets valid and clears done, finish does the opposite
  // A start wins over a finish on the same entry
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;
      done_q  <= '0;
    end else begin
      valid_q <= (valid_q & ~finish_mask) | start_mask;
      done_q  <= (done_q | finish_mask) & ~start_mask;
    end
  end

  //////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////

  assign done    = done_q;

  // Started and not yet completed
  assign pending = valid_q & ~done_q;

  // Combinational lookup for the engine
  assign sel_req = entries[sel_pos];

endmodule

// ==== source/dma_transfer_engine.sv ====
// Transfer engine FSM copying words of the lowest pending entry through the memory master port

`timescale 1ns/1ps

module dma_transfer_engine (
  input  logic                 clk,
  input  logic                 rst_n,

  // Request table side
  input  dma_pkg::entry_mask_t pending,
  output dma_pkg::entry_ptr_t  sel_pos,
  input  dma_pkg::dma_req_t    sel_req,
  output dma_pkg::entry_ptr_t  finish_pos,
  output logic                 finish_en,

  // Memory master port
  output dma_pkg::mem_req_t    mem_req,
  input  logic                 mem_ready,
  input  dma_pkg::word_t       mem_rdata
);

  import dma_pkg::*;

  //////////////////////////////////////////////////
  // State
  //////////////////////////////////////////////////

  engine_state_t state;

  // Entry being served
  entry_ptr_t    cur_pos;
  // Lowest pending entry, used only when idle
  entry_ptr_t    lowest_pos;

  // Word addresses and remaining count
  addr_t         src_addr;
  addr_t         dst_addr;
  word_count_t   count;

  // Word held between its read and its write
  word_t         data_q;

  // Memory handshake completes this cycle
  logic          mem_accept;

  //////////////////////////////////////////////////
  // Entry pick
  //////////////////////////////////////////////////

  // Scan from the top so the lowest set bit wins
  always_comb begin
    lowest_pos = '0;
    for (int i = TABLE_ENTRIES - 1; i >= 0; i--) begin
      if (pending[i]) begin
        lowest_pos = entry_ptr_t'(i);
      end
    end
  end

  // Idle looks at the candidate so its fields are ready at the same edge
  assign sel_pos = (state == st_idle) ? lowest_pos : cur_pos;

  //////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////

  assign mem_accept = mem_req.valid & mem_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= st_idle;
      cur_pos <= '0;
      count   <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (|pending) begin
            cur_pos <= lowest_pos;
            count   <= sel_req.size;
            // Empty request completes without touching memory
            state   <= (sel_req.size == '0) ? st_finish : st_read;
          end
        end
        st_read: begin
          if (mem_accept) begin
            state <= st_write;
          end
        end
        st_write: begin
          if (mem_accept) begin
            count <= count - 1'b1;
            state <= (count == word_count_t'(1)) ? st_finish : st_read;
          end
        end
        default: begin
          // Finish cycle, flag goes to the table
          state <= st_idle;
        end
      endcase
    end
  end

  // Address and data path
  always_ff @(posedge clk) begin
    if (state == st_idle) begin
      // Pick direction of the copy
      if (sel_req.dir) begin
        src_addr <= sel_req.raddr;
        dst_addr <= sel_req.laddr;
      end else begin
        src_addr <= sel_req.laddr;
        dst_addr <= sel_req.raddr;
      end
    end else if (mem_accept) begin
      if (state == st_read) begin
        data_q   <= mem_rdata;
        src_addr <= src_addr + addr_t'(WORD_BYTES);
      end else begin
        dst_addr <= dst_addr + addr_t'(WORD_BYTES);
      end
    end
  end

  //////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////

  // Built from registers only, so fields hold while mem_ready is low
  always_comb begin
    mem_req.valid = (state == st_read) || (state == st_write);
    mem_req.we    = (state == st_write);
    mem_req.addr  = (state == st_write) ? dst_addr : src_addr;
    mem_req.wdata = data_q;
  end

  // One-cycle completion pulse
  assign finish_en  = (state == st_finish);
  assign finish_pos = cur_pos;

endmodule

// ==== source/dma_top.sv ====
// Top level connecting the AHB3-Lite slave, the request table and the transfer engine

`timescale 1ns/1ps

module dma_top (
  input  logic                 clk,
  input  logic                 rst_n,

  // AHB3-Lite slave
  input  logic                 hsel,
  input  dma_pkg::addr_t       haddr,
  input  dma_pkg::word_t       hwdata,
  input  logic                 hwrite,
  input  logic                 hmastlock,
  output dma_pkg::word_t       hrdata,
  output logic                 hready,

  // Memory master
  output dma_pkg::mem_req_t    mem_req,
  input  logic                 mem_ready,
  input  dma_pkg::word_t       mem_rdata,

  // Per-entry completion flags
  output dma_pkg::entry_mask_t done
);

  import dma_pkg::*;

  //////////////////////////////////////////////////
  // Internal nets
  //////////////////////////////////////////////////

  // Bus to table
  table_wr_t   table_wr;
  entry_ptr_t  valid_pos;
  logic        valid_en;

  // Table to engine and back
  entry_mask_t pending;
  entry_ptr_t  sel_pos;
  dma_req_t    sel_req;
  entry_ptr_t  finish_pos;
  logic        finish_en;

  //////////////////////////////////////////////////
  // Instances
  //////////////////////////////////////////////////

  dma_ahb3_interface u_interface (
    .clk       (clk),
    .rst_n     (rst_n),
    .hsel      (hsel),
    .haddr     (haddr),
    .hwdata    (hwdata),
    .hwrite    (hwrite),
    .hmastlock (hmastlock),
    .hrdata    (hrdata),
    .hready    (hready),
    .table_wr  (table_wr),
    .valid_pos (valid_pos),
    .valid_en  (valid_en),
    .done      (done)
  );

  dma_request_table u_table (
    .clk        (clk),
    .rst_n      (rst_n),
    .table_wr   (table_wr),
    .valid_pos  (valid_pos),
    .valid_en   (valid_en),
    .sel_pos    (sel_pos),
    .sel_req    (sel_req),
    .finish_pos (finish_pos),
    .finish_en  (finish_en),
    .done       (done),
    .pending    (pending)
  );

  dma_transfer_engine u_engine (
    .clk        (clk),
    .rst_n      (rst_n),
    .pending    (pending),
    .sel_pos    (sel_pos),
    .sel_req    (sel_req),
    .finish_pos (finish_pos),
    .finish_en  (finish_en),
    .mem_req    (mem_req),
    .mem_ready  (mem_ready),
    .mem_rdata  (mem_rdata)
  );

endmodule

// ==== sim/dma_properties.sv ====
// Bound concurrent assertions on the AHB3-Lite response, the memory handshake and the done flags

`timescale 1ns/1ps

module dma_properties (
  input logic                 clk,
  input logic                 rst_n,
  input logic                 hsel,
  input logic                 hmastlock,
  input logic                 hready,
  input dma_pkg::mem_req_t    mem_req,
  input logic                 mem_ready,
  input dma_pkg::entry_mask_t done
);

  import dma_pkg::*;

  // Number of assertion failures so far, read by the testbench at the end
  int unsigned failures = 0;

  //////////////////////////////////////////////////
  // Bus side
  //////////////////////////////////////////////////

  // Zero wait states, every locked selected cycle completes
  hready_follows_access: assert property (
    @(posedge clk) disable iff (!rst_n)
    hready == (hsel && hmastlock)
  ) else begin
    failures++;
    $error("hready differs from hsel and hmastlock");
  end

  //////////////////////////////////////////////////
  // Memory master side
  //////////////////////////////////////////////////

  // Stalled request keeps every field
  mem_req_held_on_stall: assert property (
    @(posedge clk) disable iff (!rst_n)
    (mem_req.valid && !mem_ready) |=> $stable(mem_req)
  ) else begin
    failures++;
    $error("mem_req changed while stalled by mem_ready");
  end

  // Entries finish one at a time
  done_rises_singly: assert property (
    @(posedge clk) disable iff (!rst_n)
    $onehot0(done & ~$past(done))
  ) else begin
    failures++;
    $error("more than one done bit rose in one cycle");
  end

endmodule

bind dma_top dma_properties u_properties (
  .clk       (clk),
  .rst_n     (rst_n),
  .hsel      (hsel),
  .hmastlock (hmastlock),
  .hready    (hready),
  .mem_req   (mem_req),
  .mem_ready (mem_ready),
  .done      (done)
);

// ==== sim/dma_tb_clock.sv ====
// Testbench clock and reset generator, 20 ns period, reset low for 3 cycles

`timescale 1ns/1ps

module dma_tb_clock (
  output logic clk,
  output logic rst_n
);

  // Half of the 20 ns period
  localparam int HALF_PERIOD_NS = 10;

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD_NS) clk = ~clk;
  end

  // Synchronous reset, released on a rising edge
  initial begin
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

// ==== sim/dma_tb.sv ====
// Testbench for dma_top with the memory model, stimulus table, bus tasks, compare tasks and watchdog

`timescale 1ns/1ps

module dma_tb;

  import dma_pkg::*;

  localparam int MEM_WORDS = 256;
  localparam int NUM_ROWS  = 8;

  // One transfer request
  // chain starts it together with the next row
  typedef struct packed {
    entry_ptr_t  entry;
    addr_t       laddr;
    addr_t       raddr;
    word_count_t size;
    logic        dir;
    logic        chain;
  } stim_row_t;

  //////////////////////////////////////////////////
  // Stimulus table
  //////////////////////////////////////////////////

  // entry, laddr, raddr, size, dir, chain
  stim_row_t stim [NUM_ROWS] = '{
    '{2'd0, 32'h0000_0000, 32'h0000_0200, 16'd8, 1'b0, 1'b0},
    '{2'd1, 32'h0000_0040, 32'h0000_0280, 16'd5, 1'b1, 1'b0},
    // Three entries started back to back
    '{2'd0, 32'h0000_0080, 32'h0000_0300, 16'd3, 1'b0, 1'b1},
    '{2'd2, 32'h0000_00c0, 32'h0000_0340, 16'd6, 1'b1, 1'b1},
    '{2'd3, 32'h0000_0100, 32'h0000_0380, 16'd4, 1'b0, 1'b0},
    // Empty request followed by restarts of finished entries
    '{2'd1, 32'h0000_0140, 32'h0000_03c0, 16'd0, 1'b0, 1'b0},
    '{2'd1, 32'h0000_0180, 32'h0000_03d0, 16'd2, 1'b1, 1'b0},
    '{2'd2, 32'h0000_01c0, 32'h0000_03e0, 16'd0, 1'b0, 1'b0}
  };

  //////////////////////////////////////////////////
  // DUT signals
  //////////////////////////////////////////////////

  logic        clk;
  logic        rst_n;
  logic        hsel;
  addr_t       haddr;
  word_t       hwdata;
  logic        hwrite;
  logic        hmastlock;
  word_t       hrdata;
  logic        hready;
  mem_req_t    mem_req;
  logic        mem_ready = 1'b0;
  word_t       mem_rdata;
  entry_mask_t done;

  // Memory model and its expected copy
  word_t       mem [MEM_WORDS];
  word_t       shadow [MEM_WORDS];
  int          access_count;

  // Order in which done bits rose
  entry_mask_t done_prev = '0;
  entry_ptr_t  rise_order [$];

  dma_tb_clock u_clock (
    .clk   (clk),
    .rst_n (rst_n)
  );

  dma_top u_dma_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .hsel      (hsel),
    .haddr     (haddr),
    .hwdata    (hwdata),
    .hwrite    (hwrite),
    .hmastlock (hmastlock),
    .hrdata    (hrdata),
    .hready    (hready),
    .mem_req   (mem_req),
    .mem_ready (mem_ready),
    .mem_rdata (mem_rdata),
    .done      (done)
  );

  //////////////////////////////////////////////////
  // Failure reporting and compare tasks
  //////////////////////////////////////////////////

  task automatic fail_run(input string reason);
    $display("SIMULATION FAILED");
    $fatal(1, "%s", reason);
  endtask

  task automatic compare_word(input string name, input word_t actual, input word_t expected);
    if (actual !== expected) begin
      $display("** Error: %s is 0x%08h, expected 0x%08h", name, actual, expected);
      fail_run("word value mismatch");
    end
  endtask

  task automatic compare_mask(input string name, input entry_mask_t actual,
                              input entry_mask_t expected);
    if (actual !== expected) begin
      $display("** Error: %s is 0x%01h, expected 0x%01h", name, actual, expected);
      fail_run("entry mask mismatch");
    end
  endtask

  // Stop at the first failing bound assertion
  always @(negedge clk) begin
    if (u_dma_top.u_properties.failures != 0) begin
      fail_run("a bound assertion on dma_top failed");
    end
  end

  //////////////////////////////////////////////////
  // Memory model
  //////////////////////////////////////////////////

  // Initial content depends on every address bit
  function automatic word_t fill_word(input int idx);
    return (word_t'(idx) * 32'h9e37_79b9) ^ 32'h00a5_5a00;
  endfunction

  assign mem_rdata = mem[mem_req.addr[9:2]];

  // Reset loads the pattern
  // Ready is random and high about 3 cycles in 4
  always @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i] <= fill_word(i);
      end
      access_count = 0;
    end else if (mem_req.valid) begin
      if (mem_req.addr[31:10] != '0 || mem_req.addr[1:0] != 2'b00) begin
        fail_run($sformatf("memory access at 0x%08h lies outside the model", mem_req.addr));
      end
      if (mem_ready) begin
        access_count++;
        if (mem_req.we) begin
          mem[mem_req.addr[9:2]] <= mem_req.wdata;
        end
      end
    end
    mem_ready <= ($urandom % 32'd4) != 32'd0;
  end

  // Record every rising done bit
  always @(negedge clk) begin
    if (rst_n) begin
      for (int i = 0; i < TABLE_ENTRIES; i++) begin
        if (done[i] && !done_prev[i]) begin
          rise_order.push_back(entry_ptr_t'(i));
        end
      end
    end
    done_prev = done;
  end

  //////////////////////////////////////////////////
  // Bus tasks
  //////////////////////////////////////////////////

  function automatic addr_t field_addr(input entry_ptr_t entry, input logic [4:0] offset);
    return addr_t'({entry, offset});
  endfunction

  task automatic bus_write(input addr_t addr, input word_t data);
    @(posedge clk);
    hsel      <= 1'b1;
    hmastlock <= 1'b1;
    hwrite    <= 1'b1;
    haddr     <= addr;
    hwdata    <= data;
  endtask

  // Response sampled mid-cycle
  task automatic bus_read(input addr_t addr, output word_t data);
    @(posedge clk);
    hsel      <= 1'b1;
    hmastlock <= 1'b1;
    hwrite    <= 1'b0;
    haddr     <= addr;
    hwdata    <= '0;
    @(negedge clk);
    compare_word("hready", word_t'(hready), 32'h1);
    data = hrdata;
  endtask

  task automatic bus_idle();
    @(posedge clk);
    hsel      <= 1'b0;
    hmastlock <= 1'b0;
    hwrite    <= 1'b0;
  endtask

  task automatic program_row(input stim_row_t row);
    bus_write(field_addr(row.entry, 5'h00), row.laddr);
    bus_write(field_addr(row.entry, 5'h04), row.raddr);
    bus_write(field_addr(row.entry, 5'h08), word_t'(row.size));
    bus_write(field_addr(row.entry, 5'h0c), word_t'(row.dir));
  endtask

  //////////////////////////////////////////////////
  // Expected results
  //////////////////////////////////////////////////

  // dir 0 copies laddr to raddr and dir 1 the other way
  task automatic apply_copy(input stim_row_t row);
    int src;
    int dst;
    src = row.dir ? int'(row.raddr[9:2]) : int'(row.laddr[9:2]);
    dst = row.dir ? int'(row.laddr[9:2]) : int'(row.raddr[9:2]);
    for (int k = 0; k < int'(row.size); k++) begin
      shadow[dst + k] = shadow[src + k];
    end
  endtask

  task automatic check_memory();
    for (int i = 0; i < MEM_WORDS; i++) begin
      compare_word($sformatf("mem[0x%03h]", i * 4), mem[i], shadow[i]);
    end
  endtask

  // Poll status until every entry of the group reads done
  task automatic wait_group(input int first, input int last);
    word_t rd;
    logic  all_done;
    all_done = 1'b0;
    while (!all_done) begin
      all_done = 1'b1;
      for (int r = first; r <= last; r++) begin
        bus_read(field_addr(stim[r].entry, STATUS_OFFSET), rd);
        if (rd[0] !== 1'b1) begin
          all_done = 1'b0;
        end
      end
    end
    for (int r = first; r <= last; r++) begin
      bus_read(field_addr(stim[r].entry, STATUS_OFFSET), rd);
      compare_word("hrdata", rd, 32'h1);
    end
    bus_idle();
  endtask

  // One rise per entry in rising entry order
  task automatic check_rise_order(input int first, input int last);
    if (rise_order.size() != last - first + 1) begin
      fail_run($sformatf("%0d done bits rose for a group of %0d entries",
                         rise_order.size(), last - first + 1));
    end
    for (int k = 1; k < rise_order.size(); k++) begin
      if (rise_order[k] <= rise_order[k-1]) begin
        fail_run($sformatf("entry %0d finished after entry %0d", rise_order[k],
                           rise_order[k-1]));
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Watchdog
  //////////////////////////////////////////////////

  initial begin : watchdog
    int limit_cycles;
    limit_cycles = 0;
    for (int i = 0; i < NUM_ROWS; i++) begin
      limit_cycles += 40 * int'(stim[i].size) + 200;
    end
    repeat (limit_cycles) @(posedge clk);
    $display("SIMULATION FAILED");
    $fatal(1, "watchdog expired after %0d cycles", limit_cycles);
  end

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin : main
    int          first;
    int          last;
    int          words;
    int          accesses_before;
    entry_mask_t group_mask;
    word_t       rd;
    void'($urandom(32'h937d_3421));
    hsel      = 1'b0;
    haddr     = '0;
    hwdata    = '0;
    hwrite    = 1'b0;
    hmastlock = 1'b0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      shadow[i] = fill_word(i);
    end

    // Reset state
    @(posedge rst_n);
    @(negedge clk);
    compare_mask("done", done, '0);
    compare_word("mem_req.valid", word_t'(mem_req.valid), '0);
    for (int e = 0; e < TABLE_ENTRIES; e++) begin
      bus_read(field_addr(entry_ptr_t'(e), STATUS_OFFSET), rd);
      compare_word("hrdata", rd, '0);
    end
    bus_idle();
    check_memory();

    // Rows applied one group at a time
    first = 0;
    while (first < NUM_ROWS) begin
      last = first;
      while (stim[last].chain && last < NUM_ROWS - 1) begin
        last++;
      end
      words      = 0;
      group_mask = '0;
      for (int r = first; r <= last; r++) begin
        program_row(stim[r]);
        words += int'(stim[r].size);
        group_mask |= entry_mask_t'(1) << stim[r].entry;
      end
      accesses_before = access_count;
      rise_order.delete();
      for (int r = first; r <= last; r++) begin
        bus_write(field_addr(stim[r].entry, STATUS_OFFSET), 32'h1);
      end
      // Cycle right after the last start cannot see done yet
      bus_read(field_addr(stim[last].entry, STATUS_OFFSET), rd);
      compare_word("hrdata", rd, '0);
      wait_group(first, last);
      compare_mask("done", done & group_mask, group_mask);
      check_rise_order(first, last);
      // One read and one write per word
      compare_word("memory access count", word_t'(access_count - accesses_before),
                   word_t'(2 * words));
      for (int r = first; r <= last; r++) begin
        apply_copy(stim[r]);
      end
      check_memory();
      first = last + 1;
    end

    if (u_dma_top.u_properties.failures == 0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      $display("SIMULATION FAILED");
      $fatal(1, "%0d assertion failures", u_dma_top.u_properties.failures);
    end
  end

endmodule

// ==== all.f ====
source/dma_pkg.sv
source/dma_ahb3_interface.sv
source/dma_request_table.sv
source/dma_transfer_engine.sv
source/dma_top.sv
sim/dma_properties.sv
sim/dma_tb_clock.sv
sim/dma_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the DMA testbench with Verilator

set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  -f all.f \
  --top-module dma_tb \
  -Mdir obj_dir

# Assertion errors are counted by the testbench, so the run keeps going
./obj_dir/Vdma_tb +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q "SIMULATION PASSED" sim.log; then
  echo "run_sim: pass"
else
  echo "run_sim: fail"
  exit 1
fi
